// File: Makefile
TOP := tb_rast

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// File: files.f
+incdir+include
hdl/rast_pkg.sv
hdl/tri_setup.sv
hdl/edge_walker.sv
hdl/scan_sequencer.sv
hdl/span_stepper.sv
hdl/rast_top.sv
verif/tb_rast.sv

// File: hdl/edge_walker.sv
`include "rast_config.svh"

module edge_walker (
    input  logic            CLK,
    input  logic            RESET,
    input  logic            load,
    input  logic            step,
    input  rast_pkg::vert_t from_v,
    input  rast_pkg::vert_t to_v,
    output rast_pkg::fix_t  x,
    output rast_pkg::fix_t  z,
    output rast_pkg::fix_t  y_first,
    output rast_pkg::fix_t  y_last
);

    // Round up to the next whole pixel
    function automatic rast_pkg::fix_t ceil_fix(input rast_pkg::fix_t v);
        return (v + rast_pkg::fix_t'(`RAST_ONE - 1)) & ~rast_pkg::fix_t'(`RAST_ONE - 1);
    endfunction

    rast_pkg::fix_t dy, y_start, prestep;
    logic signed [63:0] dx_wide, dz_wide, dy_wide;
    logic signed [63:0] pre_x, pre_z;
    rast_pkg::fix_t dxdy_new, dzdy_new;

    // Walking state
    rast_pkg::fix_t x_acc, z_acc, dxdy, dzdy;

    always_comb begin
        dy      = to_v.y - from_v.y;
        y_start = ceil_fix(from_v.y);
        prestep = y_start - from_v.y;
        dx_wide = $signed(to_v.x) - $signed(from_v.x);
        dz_wide = $signed(to_v.z) - $signed(from_v.z);
        dy_wide = dy;

        // Flat edge never gets stepped
        if (dy == 0) begin
            dxdy_new = '0;
            dzdy_new = '0;
        end else begin
            dxdy_new = rast_pkg::fix_t'((dx_wide <<< `RAST_FRAC_BITS) / dy_wide);
            dzdy_new = rast_pkg::fix_t'((dz_wide <<< `RAST_FRAC_BITS) / dy_wide);
        end

        // Move the start onto the first pixel row
        pre_x = 64'(prestep) * 64'(dxdy_new);
        pre_z = 64'(prestep) * 64'(dzdy_new);
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            x_acc   <= '0;
            z_acc   <= '0;
            dxdy    <= '0;
            dzdy    <= '0;
            y_first <= '0;
            y_last  <= '0;
        end else if (load) begin
            x_acc   <= from_v.x + rast_pkg::fix_t'(pre_x >>> `RAST_FRAC_BITS);
            z_acc   <= from_v.z + rast_pkg::fix_t'(pre_z >>> `RAST_FRAC_BITS);
            dxdy    <= dxdy_new;
            dzdy    <= dzdy_new;
            y_first <= y_start;
            y_last  <= ceil_fix(to_v.y);
        end else if (step) begin
            x_acc <= x_acc + dxdy;
            z_acc <= z_acc + dzdy;
        end
    end

    assign x = ceil_fix(x_acc);
    assign z = z_acc;

endmodule

// File: hdl/rast_pkg.sv
package rast_pkg;

    // Signed coordinate, depth or slope with 8 fraction bits
    typedef logic signed [31:0] fix_t;

    // Vertex, x in the top word
    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
    } vert_t;

    // Row sequencer
    typedef enum logic [3:0] {
        seq_idle,
        seq_setup,
        seq_lower_load,
        seq_lower_wait,
        seq_lower_span,
        seq_upper_load,
        seq_upper_wait,
        seq_upper_span,
        seq_finish
    } seq_state_t;

    // Span stepper
    typedef enum logic [1:0] {
        sp_idle,
        sp_pixel,
        sp_done
    } span_state_t;

endpackage

// File: hdl/rast_top.sv
module rast_top (
    input  logic            CLK,
    input  logic            RESET,
    input  logic            start,
    input  logic            cont,
    input  rast_pkg::vert_t v1,
    input  rast_pkg::vert_t v2,
    input  rast_pkg::vert_t v3,
    output logic            pixel_valid,
    output rast_pkg::fix_t  px,
    output rast_pkg::fix_t  py,
    output rast_pkg::fix_t  pz,
    output logic            done
);

    logic            capture, setup_ready, culled;
    rast_pkg::vert_t low, mid, high;
    logic            span_start, span_done;
    rast_pkg::fix_t  span_y, left_x, left_z, right_x, right_z;

    // Triangle setup
    tri_setup i_setup (
        .CLK(CLK), .RESET(RESET), .capture(capture),
        .v1(v1), .v2(v2), .v3(v3),
        .low(low), .mid(mid), .high(high),
        .culled(culled), .setup_ready(setup_ready)
    );

    // Edge walking and row order
    scan_sequencer i_seq (
        .CLK(CLK), .RESET(RESET), .start(start),
        .setup_ready(setup_ready), .culled(culled),
        .low(low), .mid(mid), .high(high), .span_done(span_done),
        .capture(capture), .span_start(span_start), .span_y(span_y),
        .left_x(left_x), .left_z(left_z), .right_x(right_x), .right_z(right_z),
        .done(done)
    );

    // Pixels of one row
    span_stepper i_span (
        .CLK(CLK), .RESET(RESET), .span_start(span_start), .span_y(span_y),
        .left_x(left_x), .left_z(left_z), .right_x(right_x), .right_z(right_z),
        .cont(cont), .pixel_valid(pixel_valid),
        .px(px), .py(py), .pz(pz), .span_done(span_done)
    );

endmodule

// File: hdl/scan_sequencer.sv
`include "rast_config.svh"

module scan_sequencer (
    input  logic            CLK,
    input  logic            RESET,
    input  logic            start,
    input  logic            setup_ready,
    input  logic            culled,
    input  rast_pkg::vert_t low,
    input  rast_pkg::vert_t mid,
    input  rast_pkg::vert_t high,
    input  logic            span_done,
    output logic            capture,
    output logic            span_start,
    output rast_pkg::fix_t  span_y,
    output rast_pkg::fix_t  left_x,
    output rast_pkg::fix_t  left_z,
    output rast_pkg::fix_t  right_x,
    output rast_pkg::fix_t  right_z,
    output logic            done
);

    rast_pkg::seq_state_t state, state_next;
    logic [3:0]     wait_cnt;
    logic           busy;
    rast_pkg::fix_t row_y;

    logic           lo_load, up_load, lo_step, up_step, row_step;
    rast_pkg::fix_t lo_x, lo_z, lo_y_first, lo_y_last;
    rast_pkg::fix_t up_x, up_z, up_y_first, up_y_last;
    rast_pkg::fix_t lg_x, lg_z;
    logic           upper_half, in_span, row_end;
    rast_pkg::fix_t edge_x, edge_z, half_last;

    // Short edges per half, long edge spans both
    edge_walker i_lower (.CLK(CLK), .RESET(RESET), .load(lo_load), .step(lo_step),
        .from_v(low), .to_v(mid), .x(lo_x), .z(lo_z), .y_first(lo_y_first), .y_last(lo_y_last));
    edge_walker i_upper (.CLK(CLK), .RESET(RESET), .load(up_load), .step(up_step),
        .from_v(mid), .to_v(high), .x(up_x), .z(up_z), .y_first(up_y_first), .y_last(up_y_last));
    edge_walker i_long (.CLK(CLK), .RESET(RESET), .load(lo_load), .step(row_step),
        .from_v(low), .to_v(high), .x(lg_x), .z(lg_z), .y_first(), .y_last());

    assign upper_half = (state == rast_pkg::seq_upper_span);
    assign in_span    = (state == rast_pkg::seq_lower_span) || upper_half;
    assign edge_x     = upper_half ? up_x : lo_x;
    assign edge_z     = upper_half ? up_z : lo_z;
    assign half_last  = upper_half ? up_y_last : lo_y_last;
    assign row_end    = (row_y >= half_last);

    assign capture    = (state == rast_pkg::seq_idle) && start;
    assign lo_load    = (state == rast_pkg::seq_lower_load);
    assign up_load    = (state == rast_pkg::seq_upper_load);
    assign span_start = in_span && !busy && !row_end;
    assign row_step   = in_span && busy && span_done;
    assign lo_step    = row_step && !upper_half;
    assign up_step    = row_step && upper_half;
    assign done       = (state == rast_pkg::seq_finish);
    assign span_y     = row_y;

    // Leftmost active edge opens the span
    always_comb begin
        if (edge_x < lg_x) begin
            left_x  = edge_x;
            left_z  = edge_z;
            right_x = lg_x;
            right_z = lg_z;
        end else begin
            left_x  = lg_x;
            left_z  = lg_z;
            right_x = edge_x;
            right_z = edge_z;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            rast_pkg::seq_idle: if (start) state_next = rast_pkg::seq_setup;
            rast_pkg::seq_setup: begin
                if (setup_ready) begin
                    state_next = culled ? rast_pkg::seq_finish : rast_pkg::seq_lower_load;
                end
            end
            rast_pkg::seq_lower_load: state_next = rast_pkg::seq_lower_wait;
            rast_pkg::seq_lower_wait: if (wait_cnt == 0) state_next = rast_pkg::seq_lower_span;
            rast_pkg::seq_lower_span: if (!busy && row_end) state_next = rast_pkg::seq_upper_load;
            rast_pkg::seq_upper_load: state_next = rast_pkg::seq_upper_wait;
            rast_pkg::seq_upper_wait: if (wait_cnt == 0) state_next = rast_pkg::seq_upper_span;
            rast_pkg::seq_upper_span: if (!busy && row_end) state_next = rast_pkg::seq_finish;
            rast_pkg::seq_finish: if (!start) state_next = rast_pkg::seq_idle;
            default: state_next = rast_pkg::seq_idle;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= rast_pkg::seq_idle;
            wait_cnt <= '0;
            busy     <= 1'b0;
        end else begin
            state <= state_next;
            if (lo_load || up_load) begin
                wait_cnt <= 4'(`RAST_SETUP_CYCLES - 1);
            end else if (wait_cnt != 0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
            if (span_start) begin
                busy <= 1'b1;
            end else if (span_done) begin
                busy <= 1'b0;
            end
        end
    end

    // First row of each half once the walkers have settled
    always_ff @(posedge CLK) begin
        if (state == rast_pkg::seq_lower_wait && wait_cnt == 0) begin
            row_y <= lo_y_first;
        end else if (state == rast_pkg::seq_upper_wait && wait_cnt == 0) begin
            row_y <= up_y_first;
        end else if (row_step) begin
            row_y <= row_y + `RAST_ONE;
        end
    end

    // Stepper only finishes a span that is still open
    a_span_open: assert property (@(posedge CLK) disable iff (RESET)
        span_done |-> busy);

endmodule

// File: hdl/span_stepper.sv
`include "rast_config.svh"

module span_stepper (
    input  logic           CLK,
    input  logic           RESET,
    input  logic           span_start,
    input  rast_pkg::fix_t span_y,
    input  rast_pkg::fix_t left_x,
    input  rast_pkg::fix_t left_z,
    input  rast_pkg::fix_t right_x,
    input  rast_pkg::fix_t right_z,
    input  logic           cont,
    output logic           pixel_valid,
    output rast_pkg::fix_t px,
    output rast_pkg::fix_t py,
    output rast_pkg::fix_t pz,
    output logic           span_done
);

    rast_pkg::span_state_t state, state_next;
    rast_pkg::fix_t x_cnt, z_cnt, dzdx, row_y, x_end;
    rast_pkg::fix_t width, dzdx_new, x_limit;
    logic signed [63:0] dz_wide;
    logic off_screen, last_px;

    assign x_limit = `RAST_SCREEN_W * `RAST_ONE;

    // Depth slope per pixel, zero for a single-pixel span
    assign width    = right_x - left_x;
    assign dz_wide  = right_z - left_z;
    assign dzdx_new = (width == 0) ? '0 :
                      rast_pkg::fix_t'((dz_wide <<< `RAST_FRAC_BITS) / 64'(width));

    assign off_screen = (left_x >= x_limit);
    // Stop at the right edge or before the next x leaves the screen
    assign last_px    = (x_cnt >= x_end) || ((x_cnt + `RAST_ONE) >= x_limit);

    always_comb begin
        state_next = state;
        unique case (state)
            rast_pkg::sp_idle: begin
                if (span_start) begin
                    state_next = off_screen ? rast_pkg::sp_done : rast_pkg::sp_pixel;
                end
            end
            rast_pkg::sp_pixel: begin
                if (cont && last_px) state_next = rast_pkg::sp_done;
            end
            rast_pkg::sp_done: state_next = rast_pkg::sp_idle;
            default: state_next = rast_pkg::sp_idle;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= rast_pkg::sp_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == rast_pkg::sp_idle && span_start) begin
            x_cnt <= left_x;
            z_cnt <= left_z;
            dzdx  <= dzdx_new;
            row_y <= span_y;
            x_end <= right_x;
        end else if (state == rast_pkg::sp_pixel && cont && !last_px) begin
            x_cnt <= x_cnt + `RAST_ONE;
            z_cnt <= z_cnt + dzdx;
        end
    end

    assign pixel_valid = (state == rast_pkg::sp_pixel);
    assign span_done   = (state == rast_pkg::sp_done);
    assign px = x_cnt;
    assign py = row_y;
    assign pz = z_cnt;

    a_px_hold: assert property (@(posedge CLK) disable iff (RESET)
        pixel_valid && !cont |=> pixel_valid && $stable(px) && $stable(pz));

endmodule

// File: hdl/tri_setup.sv
`include "rast_config.svh"

module tri_setup (
    input  logic            CLK,
    input  logic            RESET,
    input  logic            capture,
    input  rast_pkg::vert_t v1,
    input  rast_pkg::vert_t v2,
    input  rast_pkg::vert_t v3,
    output rast_pkg::vert_t low,
    output rast_pkg::vert_t mid,
    output rast_pkg::vert_t high,
    output logic            culled,
    output logic            setup_ready
);

    // Edges leaving v1
    rast_pkg::fix_t e1_x, e1_y, e1_z;
    rast_pkg::fix_t e2_x, e2_y, e2_z;

    // Normal and facing term, wide so the sign survives
    logic signed [63:0] n_x, n_y, n_z;
    logic signed [95:0] facing;

    // Sort network
    rast_pkg::vert_t s_a, s_b, s_c, tmp;

    always_comb begin
        e1_x = v2.x - v1.x;
        e1_y = v2.y - v1.y;
        e1_z = v2.z - v1.z;
        e2_x = v3.x - v1.x;
        e2_y = v3.y - v1.y;
        e2_z = v3.z - v1.z;

        n_x = (64'(e1_y) * 64'(e2_z) - 64'(e1_z) * 64'(e2_y)) >>> `RAST_FRAC_BITS;
        n_y = (64'(e1_z) * 64'(e2_x) - 64'(e1_x) * 64'(e2_z)) >>> `RAST_FRAC_BITS;
        n_z = (64'(e1_x) * 64'(e2_y) - 64'(e1_y) * 64'(e2_x)) >>> `RAST_FRAC_BITS;

        facing = $signed(v1.x) * n_x + $signed(v1.y) * n_y + $signed(v1.z) * n_z;
    end

    // Three compare-swap stages, smallest y ends in s_a
    always_comb begin
        s_a = v1;
        s_b = v2;
        s_c = v3;
        tmp = v1;
        if ($signed(s_a.y) > $signed(s_b.y)) begin
            tmp = s_a;
            s_a = s_b;
            s_b = tmp;
        end
        if ($signed(s_b.y) > $signed(s_c.y)) begin
            tmp = s_b;
            s_b = s_c;
            s_c = tmp;
        end
        if ($signed(s_a.y) > $signed(s_b.y)) begin
            tmp = s_a;
            s_a = s_b;
            s_b = tmp;
        end
    end

    always_ff @(posedge CLK) begin
        if (capture) begin
            low  <= s_a;
            mid  <= s_b;
            high <= s_c;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            setup_ready <= 1'b0;
            culled      <= 1'b0;
        end else begin
            setup_ready <= capture;
            // Facing away or edge-on
            if (capture) begin
                culled <= (facing >= 0);
            end
        end
    end

    a_sorted_y: assert property (@(posedge CLK) disable iff (RESET)
        setup_ready |-> ($signed(low.y) <= $signed(mid.y)) && ($signed(mid.y) <= $signed(high.y)));

endmodule

// File: include/rast_config.svh
`ifndef RAST_CONFIG_SVH
`define RAST_CONFIG_SVH

// Fraction bits of the signed fixed-point format
`define RAST_FRAC_BITS 8

// One pixel unit in fixed point
`define RAST_ONE (1 << `RAST_FRAC_BITS)

// Screen width in whole pixels
`define RAST_SCREEN_W 320

// Settle cycles between an edge load and its first use
`define RAST_SETUP_CYCLES 2

`endif

// File: verif/rast_stim.txt
// First word is the triangle count. Each triangle takes two lines of hex words
// v1 x y z, v2 x y z, v3 x y z, then pixel count, px sum, py sum, last pz, stall flag
5
// Clockwise order, culled
00000400 00000200 00001200 00000A00 00000A00 00002800 00000200 00000600 00001800
00000000 00000000 00000000 00000000 0
// Both halves, z slope across every span
00000400 00000200 00001200 00000200 00000600 00001800 00000A00 00000A00 00002800
0000001E 0000AA00 0000B300 00002540 0
// Same triangle, rotated order, random stalls
00000200 00000600 00001800 00000A00 00000A00 00002800 00000400 00000200 00001200
0000001E 0000AA00 0000B300 00002540 1
// Crosses the right screen edge
00013C00 00001400 00016E00 00013A00 00001800 00017400 00014200 00001C00 00018400
00000018 001DB600 00023100 00017CD5 0
// Same clipped triangle, rotated order, random stalls
00014200 00001C00 00018400 00013C00 00001400 00016E00 00013A00 00001800 00017400
00000018 001DB600 00023100 00017CD5 1

// File: verif/tb_rast.sv
`include "rast_config.svh"

module tb_rast;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WORDS_PER_TRI = 14;
    localparam int STIM_DEPTH    = 256;
    localparam int WAIT_LIMIT    = 4000;
    localparam int UNIT          = `RAST_ONE;
    localparam int X_LIMIT       = `RAST_SCREEN_W * `RAST_ONE;

    logic            CLK;
    logic            RESET;
    logic            start;
    logic            cont;
    rast_pkg::vert_t v1, v2, v3;
    logic            pixel_valid;
    rast_pkg::fix_t  px, py, pz;
    logic            done;

    logic [31:0] stim_mem [0:STIM_DEPTH-1];
    logic [31:0] lfsr;
    int          num_tri;

    rast_top i_dut (
        .CLK(CLK), .RESET(RESET), .start(start), .cont(cont),
        .v1(v1), .v2(v2), .v3(v3),
        .pixel_valid(pixel_valid), .px(px), .py(py), .pz(pz), .done(done)
    );

    always #2 CLK = ~CLK;

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string what, input longint got, input longint expected);
        if (got != expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0d ns: %s, got %0d, expected %0d",
                $time, what, got, expected));
        end
    endtask

    task automatic run_triangle(input int t);
        int             base;
        int             waited;
        int             count;
        longint         x_sum;
        longint         y_sum;
        rast_pkg::fix_t last_z, prev_x, prev_y;
        rast_pkg::fix_t held_x, held_y, held_z;
        logic           have_prev;
        logic           holding;
        logic           stalls;
        logic           stall;

        base      = 1 + t * WORDS_PER_TRI;
        count     = 0;
        x_sum     = 0;
        y_sum     = 0;
        last_z    = '0;
        prev_x    = '0;
        prev_y    = '0;
        have_prev = 1'b0;
        holding   = 1'b0;
        stalls    = stim_mem[base + 13][0];

        @(negedge CLK);
        v1    = {stim_mem[base], stim_mem[base + 1], stim_mem[base + 2]};
        v2    = {stim_mem[base + 3], stim_mem[base + 4], stim_mem[base + 5]};
        v3    = {stim_mem[base + 6], stim_mem[base + 7], stim_mem[base + 8]};
        start = 1'b1;

        waited = 0;
        @(negedge CLK);
        while (!done) begin
            if (waited == WAIT_LIMIT) begin
                stop_with_failure($sformatf("Timeout: done never rose for triangle %0d", t));
            end
            // A pixel that was not taken must still be there unchanged
            if (holding) begin
                check_value("pixel_valid while held", pixel_valid, 1);
                check_value("px while held", px, held_x);
                check_value("py while held", py, held_y);
                check_value("pz while held", pz, held_z);
            end
            if (pixel_valid) begin
                stall = 1'b0;
                if (stalls) begin
                    lfsr  = lfsr_step(lfsr);
                    stall = lfsr[0];
                end
                if (stall) begin
                    cont    = 1'b0;
                    holding = 1'b1;
                    held_x  = px;
                    held_y  = py;
                    held_z  = pz;
                end else begin
                    cont    = 1'b1;
                    holding = 1'b0;
                    check_value("px below screen width", px < X_LIMIT, 1);
                    if (have_prev && py == prev_y) begin
                        check_value("px step within row", px, prev_x + UNIT);
                    end else if (have_prev) begin
                        check_value("row step", py, prev_y + UNIT);
                    end
                    count     = count + 1;
                    x_sum     = x_sum + px;
                    y_sum     = y_sum + py;
                    last_z    = pz;
                    prev_x    = px;
                    prev_y    = py;
                    have_prev = 1'b1;
                end
            end else begin
                cont = 1'b0;
            end
            waited = waited + 1;
            @(negedge CLK);
        end
        cont = 1'b0;

        check_value("pixel count", count, longint'($signed(stim_mem[base + 9])));
        check_value("px sum", x_sum, longint'($signed(stim_mem[base + 10])));
        check_value("py sum", y_sum, longint'($signed(stim_mem[base + 11])));
        if (count > 0) begin
            check_value("last pz", last_z, longint'($signed(stim_mem[base + 12])));
        end

        // Release the handshake and let the sequencer return to idle
        start  = 1'b0;
        waited = 0;
        while (done) begin
            if (waited == WAIT_LIMIT) begin
                stop_with_failure($sformatf("Timeout: done stayed high for triangle %0d", t));
            end
            @(negedge CLK);
            waited = waited + 1;
        end
    endtask

    initial begin
        int i;

        CLK   = 1'b0;
        RESET = 1'b1;
        start = 1'b0;
        cont  = 1'b0;
        v1    = '0;
        v2    = '0;
        v3    = '0;
        lfsr  = 32'h7e29_830a;
        for (i = 0; i < STIM_DEPTH; i++) begin
            stim_mem[i] = '0;
        end
        $readmemh("verif/rast_stim.txt", stim_mem);
        num_tri = stim_mem[0];
        if (num_tri < 1 || 1 + num_tri * WORDS_PER_TRI > STIM_DEPTH) begin
            stop_with_failure("Stimulus file holds no usable triangle count");
        end

        repeat (8) @(negedge CLK);
        RESET = 1'b0;

        for (i = 0; i < num_tri; i++) begin
            run_triangle(i);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule
